//--- logic/busMaster.sv
`timescale 1ns/1ps

module busMaster
    import riscvPkg::*;
(
    input  logic        cpuSignals,
    input  logic        rstN,
    input  busCmdT      busCmd,
    output busResultT   busResult,
    output memRequestT  memRequest,
    input  memResponseT memResponse
);

    // Request held towards memory
    logic [wordAddrWidth-1:0] reqAddr;
    logic [31:0] reqData;
    logic reqWe;
    logic reqStrobe;
    // Completion back to the sequencer
    logic doneQ;
    logic [31:0] readLatch;

    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            reqStrobe <= 1'b0;
            reqWe <= 1'b0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            if (reqStrobe) begin
                // Wait here as long as the memory needs
                if (memResponse.ready) begin
                    reqStrobe <= 1'b0;
                    reqWe <= 1'b0;
                    doneQ <= 1'b1;
                end
            end else if (busCmd.issue) begin
                reqWe <= busCmd.writeEnable;
                reqStrobe <= 1'b1;
            end
        end
    end

    // Address and data are payload, loaded with the command
    always_ff @(posedge cpuSignals) begin
        if (!reqStrobe && busCmd.issue) begin
            reqAddr <= busCmd.address;
            reqData <= busCmd.writeData;
        end
    end

    // Read data valid only in the ready cycle
    always_ff @(posedge cpuSignals) begin
        if (reqStrobe && memResponse.ready) begin
            readLatch <= memResponse.readData;
        end
    end

    assign memRequest = '{address: reqAddr, writeData: reqData,
                          writeEnable: reqWe, strobe: reqStrobe};
    assign busResult = '{done: doneQ, readData: readLatch};

    // Memory sees a frozen request until it answers
    stableWhileWaiting: assert property (@(posedge cpuSignals) disable iff (!rstN)
        reqStrobe && !memResponse.ready |=>
            reqStrobe && $stable(reqAddr) && $stable(reqData) && $stable(reqWe));

endmodule

//--- logic/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer
    import riscvPkg::*;
#(
    parameter int resetPc = 4096,
    parameter int addressSize = 13
) (
    input  logic        cpuSignals,
    input  logic        rstN,
    input  decodedInsnT decoded,
    output logic [31:0] insn,
    output aluOpT       aluOp,
    output logic [31:0] aluX,
    output logic [31:0] aluY,
    input  logic [31:0] aluResult,
    output busCmdT      busCmd,
    input  busResultT   busResult
);

    coreStateT state;
    // PC counts words and wraps inside the implemented space
    logic [addressSize-1:0] pc;
    // A bus request is open
    logic pending;
    // Second register read of SW
    logic fetchRs2;

    logic [31:0] insnReg;
    // Operand registers
    logic [31:0] x;
    logic [31:0] y;
    aluOpT aluOpReg;
    // Value for the next write, register or memory
    logic [31:0] storeData;
    // Data word address and the byte offset inside it
    logic [addressSize-1:0] dataAddr;
    logic [1:0] addrLow;

    logic needBus;
    logic [wordAddrWidth-1:0] cmdAddr;
    logic cmdWe;

    logic [7:0] lane8;
    logic [15:0] lane16;
    logic [31:0] loadValue;

    assign insn = insnReg;
    assign aluOp = aluOpReg;
    assign aluX = x;
    assign aluY = y;

    // Bus command for the current state
    always_comb begin
        needBus = 1'b1;
        cmdAddr = '0;
        cmdWe = 1'b0;
        case (state)
            stFetch:
                cmdAddr = wordAddrWidth'(pc);
            stRegFetch:
                cmdAddr = wordAddrWidth'(fetchRs2 ? decoded.rs2 : decoded.rs1);
            stDataAccess: begin
                cmdAddr = wordAddrWidth'(dataAddr);
                cmdWe = decoded.opcode == opcStore;
            end
            stRegStore: begin
                // Register words sit at their index
                cmdAddr = wordAddrWidth'(decoded.rd);
                cmdWe = 1'b1;
            end
            default:
                needBus = 1'b0;
        endcase
    end

    // Issue once per state, only with no request open
    assign busCmd = '{address: cmdAddr,
                      writeData: cmdWe ? storeData : 32'd0,
                      writeEnable: cmdWe,
                      issue: needBus && !pending};

    // Lane select and extension of loaded data
    always_comb begin
        lane8 = busResult.readData[{addrLow, 3'b000} +: 8];
        lane16 = addrLow[1] ? busResult.readData[31:16] : busResult.readData[15:0];
        case (decoded.size)
            sizeByte:
                loadValue = decoded.loadSigned ? {{24{lane8[7]}}, lane8} : {24'b0, lane8};
            sizeHalf:
                loadValue = decoded.loadSigned ? {{16{lane16[15]}}, lane16} : {16'b0, lane16};
            default:
                loadValue = busResult.readData;
        endcase
    end

    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            state <= stFetch;
            pc <= addressSize'(resetPc >> 2);
            pending <= 1'b0;
            fetchRs2 <= 1'b0;
        end else begin
            if (busCmd.issue) begin
                pending <= 1'b1;
            end else if (busResult.done) begin
                pending <= 1'b0;
            end

            case (state)
                stFetch: begin
                    if (busResult.done) begin
                        insnReg <= busResult.readData;
                        pc <= pc + 1'b1;
                        state <= stDecode;
                    end
                end

                stDecode: begin
                    case (decoded.opcode)
                        opcOpImm, opcLoad, opcStore:
                            state <= stRegFetch;
                        // LUI goes straight to the write
                        opcLui: begin
                            storeData <= decoded.imm;
                            state <= stRegStore;
                        end
                        // Unknown opcode is skipped
                        default:
                            state <= stDone;
                    endcase
                end

                stRegFetch: begin
                    if (busResult.done) begin
                        if (fetchRs2) begin
                            // rs2 is the SW data
                            storeData <= busResult.readData;
                            state <= stDataAccess;
                        end else begin
                            x <= busResult.readData;
                            y <= decoded.imm;
                            aluOpReg <= decoded.aluOp;
                            state <= stAlu;
                        end
                    end
                end

                stAlu: begin
                    if (decoded.opcode == opcOpImm) begin
                        storeData <= aluResult;
                        state <= stRegStore;
                    end else begin
                        // Effective address from rs1 plus offset
                        dataAddr <= aluResult[addressSize+1:2];
                        addrLow <= aluResult[1:0];
                        if (decoded.opcode == opcStore) begin
                            fetchRs2 <= 1'b1;
                            state <= stRegFetch;
                        end else begin
                            state <= stDataAccess;
                        end
                    end
                end

                stDataAccess: begin
                    if (busResult.done) begin
                        if (decoded.opcode == opcStore) begin
                            state <= stDone;
                        end else begin
                            storeData <= loadValue;
                            state <= stRegStore;
                        end
                    end
                end

                stRegStore: begin
                    if (busResult.done) begin
                        state <= stDone;
                    end
                end

                stDone: begin
                    fetchRs2 <= 1'b0;
                    state <= stFetch;
                end

                default:
                    state <= stFetch;
            endcase
        end
    end

    legalState: assert property (@(posedge cpuSignals) disable iff (!rstN)
        state inside {stFetch, stDecode, stRegFetch, stAlu, stDataAccess, stRegStore, stDone});

    // One request in flight, the next issue waits for done
    singleIssue: assert property (@(posedge cpuSignals) disable iff (!rstN)
        busCmd.issue |=> (!busCmd.issue throughout busResult.done[->1]));

endmodule

//--- logic/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder
    import riscvPkg::*;
(
    input  logic [31:0] insn,
    output decodedInsnT decoded
);

    logic [4:0] major;
    logic [2:0] funct3;
    logic loadOk;
    logic storeOk;
    opcodeT opcode;
    logic [31:0] imm;
    aluOpT aluOp;

    assign major = insn[6:2];
    assign funct3 = insn[14:12];

    // LB, LH, LW, LBU, LHU only
    assign loadOk = (funct3[1:0] != 2'b11) && !(funct3[2] && funct3[1]);
    // Only full word stores are kept
    assign storeOk = funct3 == 3'b010;

    // Opcode class
    always_comb begin
        opcode = opcOther;
        // Compressed encodings fall through as unknown
        if (insn[1:0] == insn32Tag) begin
            case (major)
                opcOpImm: opcode = opcOpImm;
                opcLui:   opcode = opcLui;
                opcLoad:  opcode = loadOk ? opcLoad : opcOther;
                opcStore: opcode = storeOk ? opcStore : opcOther;
                default:  opcode = opcOther;
            endcase
        end
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            // I-type
            opcOpImm, opcLoad: imm = {{20{insn[31]}}, insn[31:20]};
            // U-type, low twelve bits clear
            opcLui:   imm = {insn[31:12], 12'b0};
            // S-type, split offset
            opcStore: imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            default:  imm = '0;
        endcase
    end

    // Bit 30 is immediate data except for the right shifts
    always_comb begin
        if (opcode == opcOpImm) begin
            aluOp = aluOpT'({(funct3 == funct3ShiftRight) && insn[30], funct3});
        end else begin
            // Address computation for loads and stores
            aluOp = aluAdd;
        end
    end

    always_comb begin
        decoded.opcode = opcode;
        decoded.aluOp = aluOp;
        decoded.size = transferSizeT'(funct3[1:0]);
        // funct3 bit 2 marks the unsigned loads
        decoded.loadSigned = !funct3[2];
        // Register indices only need four bits, memory holds x0..x15
        decoded.rs1 = insn[18:15];
        decoded.rs2 = insn[23:20];
        decoded.rd = insn[10:7];
        decoded.imm = imm;
    end

endmodule

//--- logic/riscvAlu.sv
`timescale 1ns/1ps

module riscvAlu
    import riscvPkg::*;
(
    input  aluOpT       op,
    input  logic [31:0] x,
    input  logic [31:0] y,
    output logic [31:0] result
);

    // Shift amount is the low five bits only
    logic [4:0] shamt;

    assign shamt = y[4:0];

    always_comb begin
        case (op)
            aluAdd:
                result = x + y;
            aluSub:
                result = x - y;
            aluAnd:
                result = x & y;
            aluOr:
                result = x | y;
            aluXor:
                result = x ^ y;
            aluSll:
                result = x << shamt;
            aluSrl:
                result = x >> shamt;
            // Arithmetic shift keeps the sign
            aluSra:
                result = $unsigned($signed(x) >>> shamt);
            aluSlt:
                result = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            aluSltu:
                result = (x < y) ? 32'd1 : 32'd0;
            default:
                result = '0;
        endcase
    end

endmodule

//--- logic/riscvCore.sv
`timescale 1ns/1ps

module riscvCore
    import riscvPkg::*;
#(
    // Byte address of the first instruction
    parameter int resetPc = 4096,
    // Implemented word address bits
    parameter int addressSize = 13
) (
    input  logic        cpuSignals,
    input  logic        rstN,
    output memRequestT  memRequest,
    input  memResponseT memResponse
);

    logic [31:0] insn;
    decodedInsnT decoded;

    aluOpT aluOp;
    logic [31:0] aluX;
    logic [31:0] aluY;
    logic [31:0] aluResult;

    busCmdT busCmd;
    busResultT busResult;

    // Combinational decode of the instruction register
    insnDecoder decoder (
        .insn    (insn),
        .decoded (decoded)
    );

    coreSequencer #(
        .resetPc     (resetPc),
        .addressSize (addressSize)
    ) sequencer (
        .cpuSignals (cpuSignals),
        .rstN       (rstN),
        .decoded    (decoded),
        .insn       (insn),
        .aluOp      (aluOp),
        .aluX       (aluX),
        .aluY       (aluY),
        .aluResult  (aluResult),
        .busCmd     (busCmd),
        .busResult  (busResult)
    );

    riscvAlu alu (
        .op     (aluOp),
        .x      (aluX),
        .y      (aluY),
        .result (aluResult)
    );

    // Only block that touches the memory bus
    busMaster master (
        .cpuSignals  (cpuSignals),
        .rstN        (rstN),
        .busCmd      (busCmd),
        .busResult   (busResult),
        .memRequest  (memRequest),
        .memResponse (memResponse)
    );

endmodule

//--- logic/riscvPkg.sv
package riscvPkg;

    // Memory bus word address width
    localparam int wordAddrWidth = 30;
    // Register file x0..x15 lives in the lowest memory words
    localparam int regCount = 16;
    localparam int regIdxWidth = $clog2(regCount);

    // Low two bits of every uncompressed instruction
    localparam logic [1:0] insn32Tag = 2'b11;
    // funct3 of SRLI/SRAI, the only immediate ops where bit 30 selects the operation
    localparam logic [2:0] funct3ShiftRight = 3'b101;

    // Encoding is funct7 bit 30 on top of funct3
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b1000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluSra  = 4'b1101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111
    } aluOpT;

    // Instruction bits 6 to 2
    typedef enum logic [4:0] {
        opcLoad  = 5'b00000,
        opcOpImm = 5'b00100,
        opcStore = 5'b01000,
        opcLui   = 5'b01101,
        // Anything the core skips
        opcOther = 5'b11111
    } opcodeT;

    // Matches funct3 bits 1:0 of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } transferSizeT;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stRegFetch,
        stAlu,
        stDataAccess,
        stRegStore,
        stDone
    } coreStateT;

    typedef struct packed {
        opcodeT                   opcode;
        aluOpT                    aluOp;
        transferSizeT             size;
        logic                     loadSigned;
        logic [regIdxWidth-1:0]   rs1;
        logic [regIdxWidth-1:0]   rs2;
        logic [regIdxWidth-1:0]   rd;
        logic [31:0]              imm;
    } decodedInsnT;

    // Core to memory
    typedef struct packed {
        logic [wordAddrWidth-1:0] address;
        logic [31:0]              writeData;
        logic                     writeEnable;
        logic                     strobe;
    } memRequestT;

    // Memory to core
    typedef struct packed {
        logic [31:0] readData;
        logic        ready;
    } memResponseT;

    // Sequencer to bus master
    typedef struct packed {
        logic [wordAddrWidth-1:0] address;
        logic [31:0]              writeData;
        logic                     writeEnable;
        logic                     issue;
    } busCmdT;

    // Bus master back to sequencer
    typedef struct packed {
        logic        done;
        logic [31:0] readData;
    } busResultT;

endpackage

//--- src.f
logic/riscvPkg.sv
logic/insnDecoder.sv
logic/riscvAlu.sv
logic/busMaster.sv
logic/coreSequencer.sv
logic/riscvCore.sv
verification/tbMemory.sv
verification/tbRiscvCore.sv

//--- verification/tbMemory.sv
`timescale 1ns/1ps

module tbMemory
    import riscvPkg::*;
#(
    parameter int addressSize = 13,
    parameter logic [31:0] seed = 32'd17
) (
    input  logic        cpuSignals,
    input  memRequestT  memRequest,
    output memResponseT memResponse
);

    // Program, register words and data share one array
    logic [31:0] words [0:(1 << addressSize) - 1];

    logic [31:0] rngState;
    // A request is being served
    logic active;
    int waitLeft;

    function automatic logic [31:0] xorshift32();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    initial begin
        memResponse = '0;
        rngState = seed;
        active = 1'b0;
        waitLeft = 0;
    end

    // Response changes on the falling edge, the core samples on the rising one
    always @(negedge cpuSignals) begin
        if (memResponse.ready) begin
            // Strobe already dropped at the ready edge
            memResponse.ready = 1'b0;
            active = 1'b0;
        end else if (memRequest.strobe) begin
            if (!active) begin
                active = 1'b1;
                // Zero to three wait cycles
                waitLeft = int'(xorshift32() & 32'd3);
            end
            if (waitLeft == 0) begin
                memResponse.readData = words[memRequest.address[addressSize-1:0]];
                if (memRequest.writeEnable) begin
                    words[memRequest.address[addressSize-1:0]] = memRequest.writeData;
                end
                memResponse.ready = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

endmodule

//--- verification/tbRiscvCore.sv
`timescale 1ns/1ps

module tbRiscvCore
    import riscvPkg::*;
();

    localparam int resetPc = 4096;
    localparam int addressSize = 13;
    // Data area at byte 0x2000
    localparam int dataWord = 2048;
    // Base register for loads and stores
    localparam logic [3:0] baseReg = 4'd5;

    logic cpuSignals;
    logic rstN;
    memRequestT memRequest;
    memResponseT memResponse;

    logic [31:0] rngState = 32'd17;
    logic [31:0] shadow [0:(1 << addressSize) - 1];
    int refPc;
    int progWord;
    int instrCount;
    int luiWord;
    int writesExpected;
    int writesSeen;
    int checkCount;
    int errorCount;
    bit built;
    bit timedOut;

    // Monitor state
    bit firstSeen;
    bit waitingPrev;
    bit expectLuiWrite;
    bit found;
    memRequestT prevReq;
    logic [31:0] expAddr;
    logic [31:0] expData;

    riscvCore #(
        .resetPc     (resetPc),
        .addressSize (addressSize)
    ) UUT (
        .cpuSignals  (cpuSignals),
        .rstN        (rstN),
        .memRequest  (memRequest),
        .memResponse (memResponse)
    );

    tbMemory #(
        .addressSize (addressSize),
        .seed        (32'd17)
    ) memModel (
        .cpuSignals  (cpuSignals),
        .memRequest  (memRequest),
        .memResponse (memResponse)
    );

    always #50 cpuSignals = ~cpuSignals;

    function automatic logic [31:0] xorshift32();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [3:0] rs1,
                                          input logic [2:0] f3, input logic [3:0] rd,
                                          input logic [6:0] opc);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [3:0] rs2,
                                          input logic [3:0] rs1);
        return {imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    task automatic addInsn(input logic [31:0] word, input bit writes);
        memModel.words[progWord] = word;
        progWord++;
        instrCount++;
        if (writes) begin
            writesExpected++;
        end
    endtask

    // Steps the shadow memory until the next instruction that writes
    function automatic bit nextExpectedWrite(output logic [31:0] addr, output logic [31:0] data);
        logic [31:0] insn;
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] w;
        logic [31:0] r;
        logic [2:0] f3;
        logic [4:0] sh;
        int steps;
        addr = '0;
        data = '0;
        for (steps = 0; steps < (1 << addressSize); steps++) begin
            insn = shadow[refPc];
            refPc = (refPc + 1) & ((1 << addressSize) - 1);
            f3 = insn[14:12];
            a = shadow[insn[18:15]];
            imm = {{20{insn[31]}}, insn[31:20]};
            sh = insn[24:20];
            r = '0;
            // Compressed encodings are skipped
            if (insn[1:0] == 2'b11) begin
                case (insn[6:0])
                    7'h13: begin
                        case (f3)
                            3'd0: r = a + imm;
                            3'd1: r = a << sh;
                            3'd2: r = {31'b0, $signed(a) < $signed(imm)};
                            3'd3: r = {31'b0, a < imm};
                            3'd4: r = a ^ imm;
                            3'd5: begin
                                if (insn[30]) begin
                                    r = $unsigned($signed(a) >>> sh);
                                end else begin
                                    r = a >> sh;
                                end
                            end
                            3'd6: r = a | imm;
                            default: r = a & imm;
                        endcase
                        // Register words x0..x15
                        addr = 32'(insn[10:7]);
                        data = r;
                        shadow[addr] = r;
                        return 1'b1;
                    end
                    7'h37: begin
                        addr = 32'(insn[10:7]);
                        data = {insn[31:12], 12'b0};
                        shadow[addr] = data;
                        return 1'b1;
                    end
                    7'h03: begin
                        if (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7) begin
                            ea = a + imm;
                            w = shadow[ea[addressSize+1:2]] >> (8 * ea[1:0]);
                            case (f3)
                                3'd0: r = {{24{w[7]}}, w[7:0]};
                                3'd1: r = {{16{w[15]}}, w[15:0]};
                                3'd4: r = {24'b0, w[7:0]};
                                3'd5: r = {16'b0, w[15:0]};
                                default: r = w;
                            endcase
                            addr = 32'(insn[10:7]);
                            data = r;
                            shadow[addr] = r;
                            return 1'b1;
                        end
                    end
                    7'h23: begin
                        // Word store only
                        if (f3 == 3'd2) begin
                            ea = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                            addr = 32'(ea[addressSize+1:2]);
                            data = shadow[insn[23:20]];
                            shadow[addr] = data;
                            return 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
        return 1'b0;
    endfunction

    task automatic buildProgram();
        int i;
        int n;
        int op;
        int off;
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0] f3;
        logic [3:0] rd;
        for (i = 0; i < (1 << addressSize); i++) begin
            // Fill decodes as an unknown opcode and is skipped
            memModel.words[i] = {i[24:0], 7'h7f};
        end
        for (i = 0; i < 16; i++) begin
            memModel.words[i] = xorshift32();
        end
        for (i = 0; i < 8; i++) begin
            memModel.words[dataWord + i] = xorshift32();
        end
        progWord = resetPc / 4;
        // Nine immediate ops, three rounds
        for (n = 0; n < 3; n++) begin
            for (op = 0; op < 9; op++) begin
                r = xorshift32();
                f3 = (op == 8) ? 3'd5 : op[2:0];
                imm = r[11:0];
                // Round one forces negative immediates
                if (n == 1) begin
                    imm[11] = 1'b1;
                end
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {(op == 8) ? 7'h20 : 7'h00, (n == 0) ? 5'd31 : r[4:0]};
                end
                addInsn(iType(imm, r[15:12], f3, r[19:16], 7'h13), 1'b1);
            end
        end
        // ECALL is unknown here
        addInsn(32'h0000_0073, 1'b0);
        luiWord = progWord;
        addInsn({20'h00002, 1'b0, baseReg, 7'h37}, 1'b1);
        // Every load at every allowed byte offset
        for (op = 0; op < 8; op++) begin
            for (off = 0; off < 4; off++) begin
                if ((op == 0 || op == 4) || ((op == 1 || op == 5) && off[0] == 1'b0) ||
                    (op == 2 && off == 0)) begin
                    r = xorshift32();
                    rd = (r[3:0] == baseReg) ? 4'd6 : r[3:0];
                    addInsn(iType({7'b0, r[6:4], off[1:0]}, baseReg, op[2:0], rd, 7'h03), 1'b1);
                end
            end
        end
        for (n = 0; n < 3; n++) begin
            r = xorshift32();
            addInsn(sType({7'b0, r[2:0], 2'b00}, r[7:4], baseReg), 1'b1);
        end
        // Skip then continue at PC plus 4
        addInsn(32'h0000_0073, 1'b0);
        r = xorshift32();
        addInsn(iType(r[11:0], 4'd1, 3'd0, 4'd2, 7'h13), 1'b1);
        r = xorshift32();
        addInsn({r[31:12], 1'b0, 4'd9, 7'h37}, 1'b1);
    endtask

    task automatic reportResults();
        $display("Checks: %0d, errors: %0d, writes seen: %0d of %0d",
                 checkCount, errorCount, writesSeen, writesExpected);
        if (errorCount == 0 && !timedOut) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Write comparator and request monitor
    always @(posedge cpuSignals) begin
        if (rstN) begin
            if (waitingPrev) begin
                checkCount++;
                assert (memRequest == prevReq) else begin
                    errorCount++;
                    $display("FAIL %0t: request changed while waiting for ready", $time);
                end
            end
            waitingPrev = memRequest.strobe && !memResponse.ready;
            prevReq = memRequest;
            if (memRequest.strobe && !firstSeen) begin
                firstSeen = 1'b1;
                checkCount++;
                assert (!memRequest.writeEnable && memRequest.address == resetPc / 4) else begin
                    errorCount++;
                    $display("FAIL %0t: first request %0h is not a fetch at %0h",
                             $time, memRequest.address, resetPc / 4);
                end
            end
            if (memRequest.strobe && memResponse.ready) begin
                if (expectLuiWrite) begin
                    // LUI goes from fetch straight to its write
                    checkCount++;
                    assert (memRequest.writeEnable && memRequest.address == baseReg) else begin
                        errorCount++;
                        $display("FAIL %0t: LUI made another access before its write", $time);
                    end
                    expectLuiWrite = 1'b0;
                end
                if (!memRequest.writeEnable && memRequest.address == luiWord) begin
                    expectLuiWrite = 1'b1;
                end
                if (memRequest.writeEnable) begin
                    found = nextExpectedWrite(expAddr, expData);
                    writesSeen++;
                    checkCount++;
                    assert (found && 32'(memRequest.address) == expAddr &&
                            memRequest.writeData == expData) else begin
                        errorCount++;
                        $display("FAIL %0t: write %0h to word %0h, expected %0h to word %0h%s",
                                 $time, memRequest.writeData, memRequest.address, expData,
                                 expAddr, found ? "" : " (no write expected)");
                    end
                end
            end
        end
    end

    // Watchdog from the program length
    initial begin
        wait (built);
        #(instrCount * 5 * 6 * 100 * 2);
        $display("Watchdog expired at %0t, the core stalled before all expected writes", $time);
        timedOut = 1'b1;
        reportResults();
    end

    initial begin
        cpuSignals = 1'b0;
        rstN = 1'b0;
        buildProgram();
        for (int i = 0; i < (1 << addressSize); i++) begin
            shadow[i] = memModel.words[i];
        end
        refPc = resetPc / 4;
        built = 1'b1;
        // Bus stays idle through reset
        repeat (5) begin
            @(posedge cpuSignals);
            @(negedge cpuSignals);
            checkCount++;
            assert (!memRequest.strobe && !memRequest.writeEnable) else begin
                errorCount++;
                $display("FAIL %0t: strobe or writeEnable high during reset", $time);
            end
        end
        rstN = 1'b1;
        wait (writesSeen >= writesExpected);
        // Tail catches any extra write
        repeat (20) @(posedge cpuSignals);
        reportResults();
    end

endmodule
